// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_ddr_burst_model
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
ddr_pkg.sv
ddr_burst_fsm.sv
ddr_burst_timer.sv
ddr_mem_array.sv
ddr_burst_model.sv
tb_clock_gen.sv
tb_ddr_burst_model.sv

// ==== ddr_burst_fsm.sv ====
/* DDR burst request sequencer */
`timescale 1ns/1ps
`default_nettype none

module ddr_burst_fsm (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rd,
    input  logic               we,
    input  ddr_pkg::ddr_burst_t burstcnt,
    input  logic               pace_zero,
    input  logic               count_done,
    output logic               load_latency,
    output logic               load_beats,
    output ddr_pkg::ddr_burst_t beat_len,
    output logic               addr_load,
    output logic               write_beat,
    output logic               read_beat,
    output logic               busy,
    output logic               dout_ready
);

    import ddr_pkg::*;

    ddr_state_e state;
    ddr_state_e state_nxt;
    ddr_burst_t len_q;
    logic       accept;

    // Requests only get in at an idle pacing point
    assign busy   = !(state == ST_IDLE && pace_zero);
    assign accept = !busy && (rd ^ we) && (burstcnt != '0);

    assign addr_load    = accept;
    assign load_latency = accept && rd;
    // Beat count for writes at once, for reads when latency runs out
    assign load_beats   = (accept && we) || (state == ST_READ_WAIT && count_done);
    assign beat_len     = (state == ST_IDLE) ? burstcnt : len_q;

    assign write_beat = (state == ST_WRITE) && !count_done;
    assign read_beat  = (state == ST_READ) && !count_done;
    assign dout_ready = read_beat;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = we ? ST_WRITE : ST_READ_WAIT;
                end
            end
            ST_WRITE: begin
                if (count_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_READ_WAIT: begin
                if (count_done) begin
                    state_nxt = ST_READ;
                end
            end
            ST_READ: begin
                if (count_done) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Burst length kept for the read data phase
    always_ff @(posedge clk) begin
        if (accept) begin
            len_q <= burstcnt;
        end
    end

    // A loaded burst always has at least one beat to run
    a_burst_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
        load_beats |=> !count_done);

endmodule

`default_nettype wire

// ==== ddr_burst_model.sv ====
/* DDR burst memory model */
`timescale 1ns/1ps
`default_nettype none

module ddr_burst_model #(
    parameter int MEM_AW   = ddr_pkg::DEF_MEM_AW,
    parameter int PACE_W   = ddr_pkg::DEF_PACE_W,
    parameter int READ_LAT = ddr_pkg::DEF_READ_LAT
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          rd,
    input  logic                          we,
    input  logic [ddr_pkg::DDR_ADDR_W-1:0] addr,
    input  ddr_pkg::ddr_burst_t           burstcnt,
    input  ddr_pkg::ddr_word_t            din,
    input  ddr_pkg::ddr_be_t              be,
    output logic                          busy,
    output ddr_pkg::ddr_word_t            dout,
    output logic                          dout_ready
);

    import ddr_pkg::*;

    logic       pace_zero;
    logic       count_done;
    logic       load_latency;
    logic       load_beats;
    ddr_burst_t beat_len;
    logic       addr_load;
    logic       write_beat;
    logic       read_beat;

    ddr_burst_fsm u_fsm (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .rd           ( rd           ),
        .we           ( we           ),
        .burstcnt     ( burstcnt     ),
        .pace_zero    ( pace_zero    ),
        .count_done   ( count_done   ),
        .load_latency ( load_latency ),
        .load_beats   ( load_beats   ),
        .beat_len     ( beat_len     ),
        .addr_load    ( addr_load    ),
        .write_beat   ( write_beat   ),
        .read_beat    ( read_beat    ),
        .busy         ( busy         ),
        .dout_ready   ( dout_ready   )
    );

    ddr_burst_timer #(
        .PACE_W   ( PACE_W   ),
        .READ_LAT ( READ_LAT )
    ) u_timer (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .load_latency ( load_latency ),
        .load_beats   ( load_beats   ),
        .beat_len     ( beat_len     ),
        .pace_zero    ( pace_zero    ),
        .count_done   ( count_done   )
    );

    // Only the low address bits are modelled
    ddr_mem_array #(
        .MEM_AW ( MEM_AW )
    ) u_mem (
        .clk        ( clk              ),
        .arst_n     ( arst_n           ),
        .addr       ( addr[MEM_AW-1:0] ),
        .addr_load  ( addr_load        ),
        .write_beat ( write_beat       ),
        .read_beat  ( read_beat        ),
        .din        ( din              ),
        .be         ( be               ),
        .dout       ( dout             )
    );

endmodule

`default_nettype wire

// ==== ddr_burst_timer.sv ====
/* DDR pacing and beat timer */
`timescale 1ns/1ps
`default_nettype none

module ddr_burst_timer #(
    parameter int PACE_W   = 5,
    parameter int READ_LAT = 16
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_latency,
    input  logic                load_beats,
    input  ddr_pkg::ddr_burst_t beat_len,
    output logic                pace_zero,
    output logic                count_done
);

    import ddr_pkg::*;

    localparam int LEN_W = $bits(ddr_burst_t);
    localparam int LAT_W = (READ_LAT > 1) ? $clog2(READ_LAT) : 1;
    // Wide enough for either the latency or a full burst
    localparam int CNT_W = (LAT_W > LEN_W) ? LAT_W : LEN_W;

    logic [PACE_W-1:0] pace_cnt;
    logic [CNT_W-1:0]  down_cnt;

    assign pace_zero  = (pace_cnt == '0);
    assign count_done = (down_cnt == '0);

    // Free running, wraps every 2**PACE_W cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pace_cnt <= '0;
        end else begin
            pace_cnt <= pace_cnt + PACE_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            down_cnt <= '0;
        end else if (load_latency) begin
            down_cnt <= CNT_W'(READ_LAT - 1);
        end else if (load_beats) begin
            down_cnt <= CNT_W'(beat_len);
        end else if (!count_done) begin
            down_cnt <= down_cnt - CNT_W'(1);
        end
    end

    // Latency and beat loads come from different phases
    a_no_double_load: assert property (@(posedge clk) disable iff (!arst_n)
        !(load_latency && load_beats));

endmodule

`default_nettype wire

// ==== ddr_mem_array.sv ====
/* DDR model word memory */
`timescale 1ns/1ps
`default_nettype none

module ddr_mem_array #(
    parameter int MEM_AW = 10
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [MEM_AW-1:0]  addr,
    input  logic               addr_load,
    input  logic               write_beat,
    input  logic               read_beat,
    input  ddr_pkg::ddr_word_t din,
    input  ddr_pkg::ddr_be_t   be,
    output ddr_pkg::ddr_word_t dout
);

    import ddr_pkg::*;

    localparam int BYTES = $bits(ddr_be_t);
    localparam int DEPTH = 2 ** MEM_AW;

    ddr_word_t         mem [DEPTH];
    logic [MEM_AW-1:0] areg;

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign dout = mem[areg];

    // Steps once per beat, wraps at the top of memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            areg <= '0;
        end else if (addr_load) begin
            areg <= addr;
        end else if (write_beat || read_beat) begin
            areg <= areg + MEM_AW'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (write_beat) begin
            for (int b = 0; b < BYTES; b++) begin
                if (be[b]) begin
                    mem[areg][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    a_beat_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(write_beat && read_beat));

endmodule

`default_nettype wire

// ==== ddr_pkg.sv ====
/* DDR burst model shared types */
`default_nettype none

package ddr_pkg;

    // One memory word and its byte enables
    typedef logic [63:0] ddr_word_t;
    typedef logic [7:0]  ddr_be_t;

    // Burst length in words
    typedef logic [7:0]  ddr_burst_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ_WAIT,
        ST_READ
    } ddr_state_e;

    // Request address port as seen on the DDR side
    localparam int DDR_ADDR_W = 29;

    // Defaults for the top level
    localparam int DEF_MEM_AW   = 10;
    localparam int DEF_PACE_W   = 5;
    localparam int DEF_READ_LAT = 16;

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
/* Testbench clock and reset */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_ddr_burst_model.sv ====
/* DDR burst model testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_burst_model;

    import ddr_pkg::*;

    localparam int DEPTH         = 2 ** DEF_MEM_AW;
    localparam int PACE_CYCLES   = 2 ** DEF_PACE_W;
    localparam int IGNORE_WINDOW = DEF_READ_LAT + 40;
    localparam int READ_WAIT_MAX = DEF_READ_LAT + 256 + 8;

    // Worst case per burst: pacing wait, read latency, then the beats
    function automatic int burst_budget(input int bursts, input int len);
        return bursts * (PACE_CYCLES + DEF_READ_LAT + len);
    endfunction

    localparam int TIMEOUT_CYCLES = burst_budget(1, 1) + burst_budget(2, 1)
        + burst_budget(2, 8) + burst_budget(3, 1) + burst_budget(2, 40)
        + burst_budget(3, 4) + 200;

    logic                  clk;
    logic                  arst_n;
    logic                  rd;
    logic                  we;
    logic [DDR_ADDR_W-1:0] addr;
    ddr_burst_t            burstcnt;
    ddr_word_t             din;
    ddr_be_t               be;
    logic                  busy;
    ddr_word_t             dout;
    logic                  dout_ready;

    ddr_word_t  ref_mem [DEPTH];
    ddr_word_t  wr_data [$];
    ddr_be_t    wr_be [$];
    ddr_word_t  rd_words [$];
    int         lat_seen;
    ddr_burst_t beats_seen;
    int         err_cnt;
    int         check_cnt;
    int         test_err_start;
    int         cycle_cnt = 0;
    string      test_name;

    tb_clock_gen #(
        .PERIOD_NS    ( 8  ),
        .RESET_CYCLES ( 16 )
    ) u_clk (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    ddr_burst_model UUT (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .rd         ( rd         ),
        .we         ( we         ),
        .addr       ( addr       ),
        .burstcnt   ( burstcnt   ),
        .din        ( din        ),
        .be         ( be         ),
        .busy       ( busy       ),
        .dout       ( dout       ),
        .dout_ready ( dout_ready )
    );

    task automatic check_word(input string what, input ddr_word_t exp, input ddr_word_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %s: %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input ddr_burst_t exp, input ddr_burst_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %s: %s expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_start = err_cnt;
    endtask

    task automatic finish_test();
        $display("Test %-18s %0d error(s)", test_name, err_cnt - test_err_start);
    endtask

    // Byte enable rule applied to the reference copy
    task automatic mirror_write(input int idx, input ddr_word_t w, input ddr_be_t b_en);
        for (int b = 0; b < 8; b++) begin
            if (b_en[b]) begin
                ref_mem[idx][8*b +: 8] = w[8*b +: 8];
            end
        end
    endtask

    task automatic fill_write(input int n, input ddr_be_t b_en);
        wr_data.delete();
        wr_be.delete();
        for (int k = 0; k < n; k++) begin
            wr_data.push_back({$urandom, $urandom});
            wr_be.push_back(b_en);
        end
    endtask

    // Leaves the caller on the falling edge before a free slot
    task automatic wait_idle_slot();
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
    endtask

    task automatic write_burst(input int base);
        int n;
        n = wr_data.size();
        wait_idle_slot();
        we = 1'b1;
        addr = DDR_ADDR_W'(base);
        burstcnt = ddr_burst_t'(n);
        @(posedge clk);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            we = 1'b0;
            burstcnt = '0;
            if (k == 0) begin
                check_bit("busy during write burst", 1'b1, busy);
            end
            din = wr_data[k];
            be = wr_be[k];
            mirror_write((base + k) % DEPTH, wr_data[k], wr_be[k]);
            @(posedge clk);
        end
        @(negedge clk);
        din = '0;
        be = '0;
    endtask

    task automatic read_burst(input int base, input ddr_burst_t len);
        int   waited;
        logic seen;
        logic done;
        rd_words.delete();
        lat_seen = -1;
        beats_seen = '0;
        waited = 0;
        seen = 1'b0;
        done = 1'b0;
        wait_idle_slot();
        rd = 1'b1;
        addr = DDR_ADDR_W'(base);
        burstcnt = len;
        // Acceptance edge
        @(posedge clk);
        while (!done && waited < READ_WAIT_MAX) begin
            @(negedge clk);
            rd = 1'b0;
            burstcnt = '0;
            if (dout_ready) begin
                if (!seen) begin
                    lat_seen = waited;
                end
                seen = 1'b1;
                rd_words.push_back(dout);
                beats_seen = beats_seen + ddr_burst_t'(1);
            end else if (seen) begin
                done = 1'b1;
            end
            @(posedge clk);
            waited++;
        end
        if (!done) begin
            err_cnt++;
            $display("** Error %s: read burst at %0d never completed", test_name, base);
        end
    endtask

    task automatic check_read_data(input int base, input ddr_burst_t len);
        int n;
        check_count("dout_ready cycles", len, beats_seen);
        check_count("read latency", ddr_burst_t'(DEF_READ_LAT), ddr_burst_t'(lat_seen));
        n = (rd_words.size() < int'(len)) ? rd_words.size() : int'(len);
        for (int k = 0; k < n; k++) begin
            check_word($sformatf("word %0d", k), ref_mem[(base + k) % DEPTH], rd_words[k]);
        end
    endtask

    task automatic count_ready_cycles(input int cycles, output ddr_burst_t cnt);
        cnt = '0;
        repeat (cycles) begin
            @(negedge clk);
            if (dout_ready) begin
                cnt = cnt + ddr_burst_t'(1);
            end
        end
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        check_bit("busy", 1'b0, busy);
        check_bit("dout_ready", 1'b0, dout_ready);
        read_burst(0, 8'd1);
        check_read_data(0, 8'd1);
        finish_test();
    endtask

    task automatic test_single_write();
        int base;
        start_test("single_write");
        base = int'($urandom % DEPTH);
        fill_write(1, 8'hff);
        write_burst(base);
        read_burst(base, 8'd1);
        check_read_data(base, 8'd1);
        finish_test();
    endtask

    task automatic test_burst_order();
        int base;
        start_test("burst_order");
        base = int'($urandom % (DEPTH - 8));
        fill_write(8, 8'hff);
        write_burst(base);
        read_burst(base, 8'd8);
        check_read_data(base, 8'd8);
        finish_test();
    endtask

    task automatic test_byte_enables();
        int base;
        start_test("byte_enables");
        base = int'($urandom % DEPTH);
        fill_write(1, 8'hff);
        write_burst(base);
        // Second pass touches every other byte only
        fill_write(1, 8'h55);
        write_burst(base);
        read_burst(base, 8'd1);
        check_read_data(base, 8'd1);
        finish_test();
    endtask

    task automatic test_ignored_requests();
        ddr_burst_t cnt;
        start_test("ignored_requests");
        @(negedge clk);
        while (!busy) begin
            @(negedge clk);
        end
        rd = 1'b1;
        addr = '0;
        burstcnt = 8'd1;
        @(negedge clk);
        rd = 1'b0;
        burstcnt = '0;
        count_ready_cycles(IGNORE_WINDOW, cnt);
        check_count("ready cycles after read while busy", 8'd0, cnt);
        // Free slot, but an empty burst
        wait_idle_slot();
        rd = 1'b1;
        burstcnt = '0;
        @(negedge clk);
        rd = 1'b0;
        count_ready_cycles(IGNORE_WINDOW, cnt);
        check_count("ready cycles after zero length read", 8'd0, cnt);
        finish_test();
    endtask

    task automatic test_address_wrap();
        ddr_word_t w2;
        ddr_word_t w3;
        start_test("address_wrap");
        fill_write(4, 8'hff);
        w2 = wr_data[2];
        w3 = wr_data[3];
        write_burst(DEPTH - 2);
        read_burst(0, 8'd2);
        check_read_data(0, 8'd2);
        if (rd_words.size() == 2) begin
            check_word("wrapped word at 0", w2, rd_words[0]);
            check_word("wrapped word at 1", w3, rd_words[1]);
        end
        read_burst(DEPTH - 2, 8'd4);
        check_read_data(DEPTH - 2, 8'd4);
        finish_test();
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rd = 1'b0;
        we = 1'b0;
        addr = '0;
        burstcnt = '0;
        din = '0;
        be = '0;
        err_cnt = 0;
        check_cnt = 0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i] = '0;
        end
        void'($urandom(74666));
        wait (arst_n === 1'b1);
        test_reset_state();
        test_single_write();
        test_burst_order();
        test_byte_enables();
        test_ignored_requests();
        test_address_wrap();
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
